// ==== hdl/uart_ctl.sv ====
// register port of the UART, four-phase req/ack towards the host
// holds configuration and overflow flag, moves bytes into and out of the FIFOs

`timescale 1ns/1ps
`default_nettype none

module uart_ctl import uart_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // host port
  input  logic              req,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [BUS_W-1:0]  wdata,
  output logic              ack,
  output logic [BUS_W-1:0]  rdata,
  // configuration to both directions
  output logic [BAUD_W-1:0] cfg_bdr,
  output logic [BAUD_W-1:0] cfg_smp,
  // transmit FIFO write side
  input  logic              tx_full,
  output logic              tx_push,
  output logic [DATA_W-1:0] tx_wdat,
  // receive FIFO
  input  logic              rx_empty,
  input  logic              rx_full,
  input  logic [DATA_W-1:0] rx_rdat,
  output logic              rx_pop,
  output logic              rx_push,
  output logic [DATA_W-1:0] rx_wdat,
  // deserializer stream
  input  logic              str_vld,
  input  logic [DATA_W-1:0] str_dat
);

  logic [1:0] state;

  // write word, config register and read word
  uart_word_u wword;
  uart_word_u cfg_q;
  uart_word_u rword;

  logic [BUS_W-1:0] st_word;
  logic ovf;

  // access finishes this cycle
  logic acc_go;
  logic is_data;

  assign wword   = wdata;
  assign is_data = addr == REG_DATA;

  // data write waits for space in the tx FIFO
  assign acc_go = (state == CTL_ACCESS) && !(we && is_data && tx_full);

  ////////////////////////////////////////////////////////////////////////////
  // FIFO access
  ////////////////////////////////////////////////////////////////////////////

  assign tx_push = acc_go && we && is_data;
  assign tx_wdat = wword.data.chr;
  assign rx_pop  = acc_go && !we && is_data && !rx_empty;

  // no ready towards des, a full rx FIFO drops the byte
  assign rx_push = str_vld && !rx_full;
  assign rx_wdat = str_dat;

  assign cfg_bdr = cfg_q.cfg.bdr;
  assign cfg_smp = cfg_q.cfg.smp;

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    st_word              = '0;
    st_word[ST_RX_AVAIL] = !rx_empty;
    st_word[ST_TX_FULL]  = tx_full;
    st_word[ST_RX_OVF]   = ovf;
  end

  always_comb begin
    rword = '0;
    case (addr)
      // empty rx FIFO reads as zero
      REG_DATA:   if (!rx_empty) rword.data.chr = rx_rdat;
      REG_STATUS: rword = st_word;
      REG_CFG:    rword = cfg_q;
      default:    rword = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM, config and overflow
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= CTL_IDLE;
      ack   <= 1'b0;
      cfg_q <= '0;
      ovf   <= 1'b0;
    end else begin
      case (state)
        CTL_IDLE:    if (req) state <= CTL_ACCESS;
        CTL_ACCESS:  if (acc_go) begin
          ack   <= 1'b1;
          state <= CTL_RELEASE;
        end
        // hold ack until host lets go
        CTL_RELEASE: if (!req) begin
          ack   <= 1'b0;
          state <= CTL_IDLE;
        end
        default:     state <= CTL_IDLE;
      endcase
      if (acc_go && we && addr == REG_CFG) cfg_q <= wword;
      // a new loss wins over a clearing status read
      if (str_vld && rx_full)                      ovf <= 1'b1;
      else if (acc_go && !we && addr == REG_STATUS) ovf <= 1'b0;
    end
  end

  // rdata stays put while ack is high
  always_ff @(posedge clk) begin
    if (acc_go && !we) rdata <= rword;
  end

  // ack is set on the edge after the one that still saw req
  a_ack_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

// ==== hdl/uart_des.sv ====
// receive side deserializer, turns 8N1 frames on rxd into a byte stream
// the stream has no ready, a byte is offered for exactly one cycle

`timescale 1ns/1ps
`default_nettype none

module uart_des import uart_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [BAUD_W-1:0] cfg_bdr,
  input  logic [BAUD_W-1:0] cfg_smp,
  input  logic              rxd,
  output logic              str_vld,
  output logic [DATA_W-1:0] str_dat
);

  // start edge detection
  logic rxd_dly;
  logic rxd_edg;

  // baud counter and sample point
  logic [BAUD_W-1:0] bdr_cnt;
  logic bdr_end;
  logic bdr_smp;

  // bit counter
  logic [SHF_CW-1:0] shf_cnt;
  logic shf_end;
  logic shf_run;

  // data and stop bits, start falls off the bottom
  logic [DATA_W+STOP_W-1:0] shf_dat;

  ////////////////////////////////////////////////////////////////////////////
  // start edge
  ////////////////////////////////////////////////////////////////////////////

  // line idles high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) rxd_dly <= 1'b1;
    else     rxd_dly <= rxd;
  end

  assign rxd_edg = rxd_dly & ~rxd;

  ////////////////////////////////////////////////////////////////////////////
  // baud and bit counters
  ////////////////////////////////////////////////////////////////////////////

  assign bdr_end = bdr_cnt == cfg_bdr;
  assign bdr_smp = bdr_cnt == cfg_smp;
  assign shf_end = shf_cnt == SHF_LAST;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
      shf_cnt <= '0;
      shf_run <= 1'b0;
    end else if (!shf_run) begin
      bdr_cnt <= '0;
      // wait for the falling start edge
      if (rxd_edg) begin
        shf_cnt <= '0;
        shf_run <= 1'b1;
      end
    end else begin
      bdr_cnt <= bdr_end ? '0 : bdr_cnt + 1'b1;
      // stop once the last stop bit is sampled, not at bit end
      if (shf_end && bdr_smp) begin
        shf_cnt <= '0;
        shf_run <= 1'b0;
      end else if (!shf_end && bdr_end) begin
        shf_cnt <= shf_cnt + 1'b1;
      end
    end
  end

  // lsb first, shifted in from the top
  always_ff @(posedge clk) begin
    if (shf_run && bdr_smp) shf_dat <= {rxd, shf_dat[DATA_W+STOP_W-1:1]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // output stream
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) str_vld <= 1'b0;
    else     str_vld <= shf_run & shf_end & bdr_smp;
  end

  assign str_dat = shf_dat[DATA_W-1:0];

  // a sample point past the bit end is never reached
  a_smp_range: assert property (@(posedge clk) disable iff (rst)
    shf_run |-> cfg_smp <= cfg_bdr);

endmodule

`default_nettype wire

// ==== hdl/uart_fifo.sv ====
// synchronous byte FIFO, one instance per direction
// read data is shown ahead, a pushed byte is readable after one edge

`timescale 1ns/1ps
`default_nettype none

module uart_fifo import uart_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  logic [DATA_W-1:0] wdat,
  input  logic              pop,
  output logic [DATA_W-1:0] rdat,
  output logic              full,
  output logic              empty
);

  // storage
  logic [DATA_W-1:0] mem [FIFO_DEPTH];

  // msb is the wrap bit
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;

  ////////////////////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr[FIFO_AW-1:0]] <= wdat;
  end

  assign rdat = mem[rd_ptr[FIFO_AW-1:0]];

  // same slot, wrap bits tell full from empty
  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // the producer and consumer must respect the flags
  ////////////////////////////////////////////////////////////////////////////

  a_no_ovr: assert property (@(posedge clk) disable iff (rst) push |-> !full);
  a_no_udr: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
// shared widths, register map and bus word layout for the UART controller
// imported by every RTL module and by the testbench

`default_nettype none

package uart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // character and counter widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 8;
  localparam int unsigned STOP_W = 1;
  localparam int unsigned BAUD_W = 8;

  // start + data + stop
  localparam int unsigned SHF_LEN = 1 + DATA_W + STOP_W;
  localparam int unsigned SHF_CW = 4;
  localparam logic [SHF_CW-1:0] SHF_LAST = SHF_CW'(SHF_LEN - 1);

  ////////////////////////////////////////////////////////////////////////////
  // host port and register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned BUS_W = 16;
  localparam int unsigned ADDR_W = 2;

  // write pushes tx, read pops rx
  localparam logic [ADDR_W-1:0] REG_DATA = 2'd0;
  // read only, read clears overflow
  localparam logic [ADDR_W-1:0] REG_STATUS = 2'd1;
  localparam logic [ADDR_W-1:0] REG_CFG = 2'd2;

  // status bit positions
  localparam int unsigned ST_RX_AVAIL = 0;
  localparam int unsigned ST_TX_FULL = 1;
  localparam int unsigned ST_RX_OVF = 2;

  // fifo geometry, pointers carry one extra wrap bit
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned FIFO_AW = 3;

  // register port FSM encoding
  localparam logic [1:0] CTL_IDLE = 2'd0;
  localparam logic [1:0] CTL_ACCESS = 2'd1;
  localparam logic [1:0] CTL_RELEASE = 2'd2;

  // one bus word, seen as configuration or as a character
  typedef union packed {
    struct packed {
      logic [BAUD_W-1:0] smp;
      logic [BAUD_W-1:0] bdr;
    } cfg;
    struct packed {
      logic [BUS_W-DATA_W-1:0] rsv;
      logic [DATA_W-1:0]       chr;
    } data;
  } uart_word_u;

endpackage

`default_nettype wire

// ==== hdl/uart_ser.sv ====
// transmit side serializer, pops the tx FIFO and sends 8N1 frames on txd
// one bit lasts cfg_bdr+1 clock cycles

`timescale 1ns/1ps
`default_nettype none

module uart_ser import uart_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [BAUD_W-1:0] cfg_bdr,
  input  logic              fifo_empty,
  input  logic [DATA_W-1:0] fifo_rdat,
  output logic              fifo_pop,
  output logic              txd
);

  // baud counter
  logic [BAUD_W-1:0] bdr_cnt;
  logic bdr_end;

  // bit counter and frame state
  logic [SHF_CW-1:0] shf_cnt;
  logic shf_run;

  // start, data and stop, bit 0 is on the line
  logic [SHF_LEN-1:0] shf_dat;

  // take a byte as soon as idle
  assign fifo_pop = !shf_run && !fifo_empty;

  assign bdr_end = bdr_cnt == cfg_bdr;

  ////////////////////////////////////////////////////////////////////////////
  // frame control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
      shf_cnt <= '0;
      shf_run <= 1'b0;
    end else if (fifo_pop) begin
      bdr_cnt <= '0;
      shf_cnt <= '0;
      shf_run <= 1'b1;
    end else if (shf_run) begin
      bdr_cnt <= bdr_end ? '0 : bdr_cnt + 1'b1;
      if (bdr_end) begin
        // end of stop bit frees the serializer
        if (shf_cnt == SHF_LAST) shf_run <= 1'b0;
        else                     shf_cnt <= shf_cnt + 1'b1;
      end
    end
  end

  // load a whole frame, then shift towards bit 0
  always_ff @(posedge clk) begin
    if (fifo_pop)                shf_dat <= {{STOP_W{1'b1}}, fifo_rdat, 1'b0};
    else if (shf_run && bdr_end) shf_dat <= {1'b1, shf_dat[SHF_LEN-1:1]};
  end

  // idle line is high
  assign txd = !shf_run || shf_dat[0];

  // a divisor lowered mid-frame would let the counter run past the bit end
  a_bdr_range: assert property (@(posedge clk) disable iff (rst)
    shf_run |-> bdr_cnt <= cfg_bdr);

endmodule

`default_nettype wire

// ==== hdl/uart_top.sv ====
// UART controller top, register port plus tx and rx paths
// txd and rxd are the serial pins, the rest is the host port

`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [BUS_W-1:0]  wdata,
  output logic              ack,
  output logic [BUS_W-1:0]  rdata,
  input  logic              rxd,
  output logic              txd
);

  logic [BAUD_W-1:0] cfg_bdr;
  logic [BAUD_W-1:0] cfg_smp;

  // transmit path
  logic              tx_push;
  logic [DATA_W-1:0] tx_wdat;
  logic              tx_pop;
  logic [DATA_W-1:0] tx_rdat;
  logic              tx_full;
  logic              tx_empty;

  // receive path
  logic              rx_push;
  logic [DATA_W-1:0] rx_wdat;
  logic              rx_pop;
  logic [DATA_W-1:0] rx_rdat;
  logic              rx_full;
  logic              rx_empty;
  logic              str_vld;
  logic [DATA_W-1:0] str_dat;

  uart_ctl ctl (
    .clk, .rst, .req, .we, .addr, .wdata, .ack, .rdata,
    .cfg_bdr, .cfg_smp,
    .tx_full, .tx_push, .tx_wdat,
    .rx_empty, .rx_full, .rx_rdat, .rx_pop, .rx_push, .rx_wdat,
    .str_vld, .str_dat
  );

  uart_fifo tx_fifo (
    .clk, .rst, .push(tx_push), .wdat(tx_wdat), .pop(tx_pop),
    .rdat(tx_rdat), .full(tx_full), .empty(tx_empty)
  );

  uart_fifo rx_fifo (
    .clk, .rst, .push(rx_push), .wdat(rx_wdat), .pop(rx_pop),
    .rdat(rx_rdat), .full(rx_full), .empty(rx_empty)
  );

  uart_ser ser (
    .clk, .rst, .cfg_bdr, .fifo_empty(tx_empty), .fifo_rdat(tx_rdat),
    .fifo_pop(tx_pop), .txd
  );

  uart_des des (.clk, .rst, .cfg_bdr, .cfg_smp, .rxd, .str_vld, .str_dat);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the UART testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module uart_tb \
    -Mdir obj_dir -o uart_sim \
  && ./obj_dir/uart_sim 2>&1 | tee sim.log \
  && ! grep -q "TEST FAIL" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim.f ====
+incdir+include
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_ser.sv
hdl/uart_des.sv
hdl/uart_ctl.sv
hdl/uart_top.sv
sim/uart_tb.sv

// ==== include/uart_tb_tasks.svh ====
// host bus tasks and expected-byte bookkeeping for the UART testbench
// include inside the testbench module, after clk and the host port signals

`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// bytes sent but not yet read back
logic [DATA_W-1:0] exp_q [$];
int unsigned err_cnt = 0;
int unsigned chk_cnt = 0;

// four-phase write, inputs change on the falling edge
task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [BUS_W-1:0] d);
  @(negedge clk);
  addr  = a;
  we    = 1'b1;
  wdata = d;
  req   = 1'b1;
  // a full tx FIFO stretches this
  while (!ack) @(negedge clk);
  req = 1'b0;
  we  = 1'b0;
  while (ack) @(negedge clk);
endtask

// four-phase read, rdata taken while ack is high
task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [BUS_W-1:0] d);
  @(negedge clk);
  addr = a;
  we   = 1'b0;
  req  = 1'b1;
  while (!ack) @(negedge clk);
  d = rdata;
  // req held one more cycle so ack spans two edges
  @(negedge clk);
  req = 1'b0;
  while (ack) @(negedge clk);
endtask

// compare one word, report in hex
task automatic chk_eq(input string name, input logic [BUS_W-1:0] got,
                      input logic [BUS_W-1:0] want);
  chk_cnt++;
  if (got !== want) begin
    $display("ERROR %s: got 0x%04h, expected 0x%04h", name, got, want);
    err_cnt++;
  end
endtask

function automatic void exp_push(input logic [DATA_W-1:0] b);
  exp_q.push_back(b);
endfunction

// next received byte must match the oldest sent one
task automatic exp_check(input logic [BUS_W-1:0] got);
  logic [DATA_W-1:0] want;
  if (exp_q.size() == 0) begin
    chk_cnt++;
    err_cnt++;
    $display("ERROR rdata: got 0x%04h, expected queue empty", got);
  end else begin
    want = exp_q.pop_front();
    chk_eq("rdata", got, {{(BUS_W-DATA_W){1'b0}}, want});
  end
endtask

`endif

// ==== sim/uart_tb.sv ====
// self-checking testbench for the UART controller, txd looped back to rxd
// runs config, burst, status and overflow sequences through the host port

`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

  // line timing used by every sequence
  localparam int unsigned TB_BDR = 7;
  localparam int unsigned TB_SMP = 3;
  localparam int unsigned BIT_CYC = TB_BDR + 1;
  localparam int unsigned FRM_CYC = 10 * BIT_CYC;

  // byte counts per sequence
  localparam int unsigned N_BURST = 12;
  localparam int unsigned N_OVF = FIFO_DEPTH + 1;
  localparam int unsigned WDOG_CYC = 2 * ((N_BURST + N_OVF) * FRM_CYC + 1000);

  logic              clk;
  logic              rst;
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [BUS_W-1:0]  wdata;
  logic              ack;
  logic [BUS_W-1:0]  rdata;

  // serial loopback, txd drives rxd
  logic line;

  logic [DATA_W-1:0] burst [N_BURST];

  `include "uart_tb_tasks.svh"

  uart_top UUT (
    .clk, .rst, .req, .we, .addr, .wdata, .ack, .rdata,
    .rxd(line), .txd(line)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake rules seen from the host side
  ////////////////////////////////////////////////////////////////////////////

  // ack two edges after req, except a data write that may stall
  a_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) && !$past(we && addr == REG_DATA, 1) |-> $past(req, 2) && !$past(req, 3))
    else begin
      $display("ack rose at the wrong distance from req");
      err_cnt++;
    end

  // release takes one edge
  a_ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(req) |=> $fell(ack))
    else begin
      $display("ack did not drop one edge after req was released");
      err_cnt++;
    end

  a_rdata_hold: assert property (@(posedge clk) disable iff (rst)
    ack && $past(ack) && !we |-> $stable(rdata))
    else begin
      $display("rdata changed while ack was high");
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // line helpers
  ////////////////////////////////////////////////////////////////////////////

  // whole 8N1 frame on the line, one check per cycle
  task automatic watch_frame(input logic [DATA_W-1:0] b);
    logic [SHF_LEN-1:0] bits;
    int unsigned k;
    bits = {1'b1, b, 1'b0};
    @(negedge clk);
    // first cycle of the start bit
    while (line) @(negedge clk);
    for (k = 0; k < SHF_LEN * BIT_CYC; k++) begin
      chk_cnt++;
      assert (line === bits[k / BIT_CYC]) else begin
        $display("ERROR txd: got 0x%0h, expected 0x%0h in bit %0d",
                 line, bits[k / BIT_CYC], k / BIT_CYC);
        err_cnt++;
      end
      @(negedge clk);
    end
  endtask

  // line high for n cycles in a row means nothing is in flight
  task automatic wait_line_idle(input int unsigned n);
    int unsigned run;
    run = 0;
    while (run < n) begin
      @(negedge clk);
      run = line ? run + 1 : 0;
    end
  endtask

  // poll status until a received byte is waiting
  task automatic wait_rx_avail();
    logic [BUS_W-1:0] st;
    st = '0;
    while (!st[ST_RX_AVAIL]) bus_read(REG_STATUS, st);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYC);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt + 1);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [BUS_W-1:0]  rd;
    logic [BUS_W-1:0]  st_exp;
    logic [DATA_W-1:0] b;
    int unsigned i;
    rst   = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    void'($urandom(85));
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // idle after reset
    chk_cnt++;
    assert (ack === 1'b0) else begin
      $display("ERROR ack: got 0x%0h, expected 0x0", ack);
      err_cnt++;
    end
    chk_cnt++;
    assert (line === 1'b1) else begin
      $display("ERROR txd: got 0x%0h, expected 0x1", line);
      err_cnt++;
    end
    bus_read(REG_STATUS, rd);
    chk_eq("status", rd, '0);

    // sample position high byte, divisor low byte
    bus_write(REG_CFG, {BAUD_W'(TB_SMP), BAUD_W'(TB_BDR)});
    bus_read(REG_CFG, rd);
    chk_eq("cfg", rd, {BAUD_W'(TB_SMP), BAUD_W'(TB_BDR)});

    // burst longer than the tx FIFO, later writes stall
    for (i = 0; i < N_BURST; i++) burst[i] = DATA_W'($urandom());
    fork
      watch_frame(burst[0]);
      begin
        for (i = 0; i < N_BURST; i++) begin
          bus_write(REG_DATA, {{(BUS_W-DATA_W){1'b0}}, burst[i]});
          exp_push(burst[i]);
        end
      end
    join

    // drain faster than frames arrive
    for (i = 0; i < N_BURST; i++) begin
      wait_rx_avail();
      bus_read(REG_DATA, rd);
      exp_check(rd);
    end
    bus_read(REG_STATUS, rd);
    chk_cnt++;
    assert (rd[ST_RX_AVAIL] === 1'b0) else begin
      $display("ERROR status rx_avail: got 0x%0h, expected 0x0", rd[ST_RX_AVAIL]);
      err_cnt++;
    end
    chk_eq("status", rd, '0);

    // one byte more than the rx FIFO holds, nothing read meanwhile
    for (i = 0; i < N_OVF; i++) begin
      b = DATA_W'($urandom());
      bus_write(REG_DATA, {{(BUS_W-DATA_W){1'b0}}, b});
      exp_push(b);
    end
    wait_line_idle(2 * FRM_CYC);
    st_exp              = '0;
    st_exp[ST_RX_AVAIL] = 1'b1;
    st_exp[ST_RX_OVF]   = 1'b1;
    bus_read(REG_STATUS, rd);
    chk_eq("status", rd, st_exp);

    // last byte was dropped
    void'(exp_q.pop_back());
    for (i = 0; i < FIFO_DEPTH; i++) begin
      bus_read(REG_DATA, rd);
      exp_check(rd);
    end
    // previous status read cleared the flag
    bus_read(REG_STATUS, rd);
    chk_eq("status", rd, '0);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
